/* all.f */
+incdir+.
csr_pkg.sv
csr_alu.sv
csr_timer.sv
csr_trap_ctrl.sv
csr_regfile.sv
csr_unit_top.sv
tb_csr_unit.sv

/* run.sh */
#!/bin/sh
# builds the CSR unit testbench with Verilator and runs it
# a $fatal in the testbench gives a non-zero exit status
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wall -Wno-fatal \
	-f all.f \
	--top-module tb_csr_unit \
	-o sim_csr_unit
./obj_dir/sim_csr_unit

/* tb_csr_unit.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"

module tb_csr_unit;

	logic clk;
	logic nrst;
	csr_pkg::csr_req_t csr_req;
	csr_pkg::trap_req_t trap_req;
	csr_pkg::ret_t ret;
	csr_pkg::ext_irq_t ext_irq;
	logic [`XLEN-1:0] rd_data;
	csr_pkg::mode_t current_mode;
	logic [`XLEN-1:0] epc;
	csr_pkg::irq_en_t irq_en;
	csr_pkg::timer_irq_t timer_irq;

	logic [15:0] lfsr;
	int cycles;

	// shadow state of the reference model
	csr_pkg::mode_t m_mode;
	logic [31:0] m_status, m_ie, m_mtvec, m_mepc, m_sepc, m_uepc;
	logic [31:0] m_mcause, m_scause, m_ucause, m_mscratch, m_sscratch;
	logic [31:0] m_medeleg, m_mideleg, m_sedeleg, m_sideleg;
	logic [63:0] m_mtimecmp, m_time;
	csr_pkg::timer_irq_t m_tirq;

	csr_unit_top u_dut (.clk(clk), .nrst(nrst), .csr_req(csr_req), .trap_req(trap_req),
		.ret(ret), .ext_irq(ext_irq), .rd_data(rd_data), .current_mode(current_mode),
		.epc(epc), .irq_en(irq_en), .timer_irq(timer_irq));

	always #20 clk = ~clk;

	// taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] ref_read(input csr_pkg::csr_addr_t a);
		case (a)
			csr_pkg::CSR_MSTATUS: return m_status;
			csr_pkg::CSR_MISA: return `MISA_VALUE;
			csr_pkg::CSR_MIE: return m_ie;
			csr_pkg::CSR_UIE: return m_ie & 32'h111;
			csr_pkg::CSR_MTVEC: return m_mtvec;
			csr_pkg::CSR_MSCRATCH: return m_mscratch;
			csr_pkg::CSR_SSCRATCH: return m_sscratch;
			csr_pkg::CSR_MEPC: return m_mepc;
			csr_pkg::CSR_SEPC: return m_sepc;
			csr_pkg::CSR_UEPC: return m_uepc;
			csr_pkg::CSR_MCAUSE: return m_mcause;
			csr_pkg::CSR_SCAUSE: return m_scause;
			csr_pkg::CSR_UCAUSE: return m_ucause;
			csr_pkg::CSR_MEDELEG: return m_medeleg;
			csr_pkg::CSR_MIDELEG: return m_mideleg;
			csr_pkg::CSR_SEDELEG: return m_sedeleg;
			csr_pkg::CSR_SIDELEG: return m_sideleg;
			csr_pkg::CSR_MTIMECMP: return m_mtimecmp[31:0];
			csr_pkg::CSR_MIP: return {24'b0, m_tirq.m, 1'b0, m_tirq.s, m_tirq.u, 4'b0};
			default: return '0; // id registers
		endcase
	endfunction

	// delegation rule, M keeps all traps
	function automatic csr_pkg::mode_t ref_target();
		logic [31:0] md;
		logic [31:0] sd;
		md = trap_req.interrupt ? m_mideleg : m_medeleg;
		sd = trap_req.interrupt ? m_sideleg : m_sedeleg;
		if (m_mode == csr_pkg::MODE_M)
			return csr_pkg::MODE_M;
		if (m_mode == csr_pkg::MODE_S)
			return md[trap_req.code] ? csr_pkg::MODE_S : csr_pkg::MODE_M;
		return sd[trap_req.code] ? csr_pkg::MODE_U : csr_pkg::MODE_S;
	endfunction

	function automatic logic [31:0] ref_epc();
		csr_pkg::mode_t m;
		m = trap_req.pending ? ref_target() : m_mode;
		if (!trap_req.pending && ret == csr_pkg::RET_MRET)
			return m_mepc;
		if (!trap_req.pending && ret == csr_pkg::RET_SRET)
			return m_sepc;
		if (!trap_req.pending && ret == csr_pkg::RET_URET)
			return m_uepc;
		return (m == csr_pkg::MODE_M) ? m_mtvec : 32'h0; // stvec and utvec stay zero
	endfunction

	function automatic csr_pkg::irq_en_t ref_irq_en();
		csr_pkg::irq_en_t e;
		e.m_eie = m_ie[11] & m_status[3];
		e.m_tie = m_ie[7] & m_status[3];
		e.s_eie = m_ie[9] & m_status[1];
		e.s_tie = m_ie[5] & m_status[1];
		e.u_eie = m_ie[8] & m_status[0];
		e.u_tie = m_ie[4] & m_status[0];
		e.u_sie = m_ie[0] & m_status[0];
		return e;
	endfunction

	task automatic ref_write(input csr_pkg::csr_addr_t a, input logic [31:0] d);
		logic [1:0] mpp;
		case (a)
			csr_pkg::CSR_MSTATUS:
			begin
				mpp = (d[12:11] == 2'b10) ? m_status[12:11] : d[12:11];
				m_status = (d & 32'h01bb) | {19'b0, mpp, 11'b0};
			end
			csr_pkg::CSR_MIE: m_ie = d & 32'hbb1;
			csr_pkg::CSR_UIE: m_ie = (m_ie & ~32'h111) | (d & 32'h111);
			csr_pkg::CSR_MTVEC: m_mtvec = d & ~32'h3;
			csr_pkg::CSR_MSCRATCH: m_mscratch = d;
			csr_pkg::CSR_SSCRATCH: m_sscratch = d;
			csr_pkg::CSR_MEDELEG: m_medeleg = d & 32'hffff;
			csr_pkg::CSR_MIDELEG: m_mideleg = d & 32'hfff;
			csr_pkg::CSR_SEDELEG: m_sedeleg = d & 32'hffff;
			csr_pkg::CSR_SIDELEG: m_sideleg = d & 32'hfff;
			csr_pkg::CSR_MTIMECMP: m_mtimecmp = {32'b0, d};
			default: ;
		endcase
	endtask

	task automatic model_reset();
		m_mode = csr_pkg::MODE_M;
		m_status = 32'h1800; // MPP = M
		{m_ie, m_mtvec, m_mepc, m_sepc, m_uepc, m_mscratch, m_sscratch} = '0;
		{m_mcause, m_scause, m_ucause} = '0;
		{m_medeleg, m_mideleg, m_sedeleg, m_sideleg} = '0;
		m_mtimecmp = '0;
		m_time = '0;
		m_tirq = '0;
	endtask

	task automatic model_step();
		csr_pkg::mode_t tgt;
		logic [31:0] od;
		logic [31:0] cause;
		logic ro;
		tgt = ref_target();
		cause = {trap_req.interrupt, 26'b0, trap_req.code};
		// misa, the id registers and the counters
		ro = csr_req.addr inside {csr_pkg::CSR_MISA, csr_pkg::CSR_MVENDORID,
			csr_pkg::CSR_MARCHID, csr_pkg::CSR_MIMPID, csr_pkg::CSR_MHARTID,
			csr_pkg::CSR_CYCLE, csr_pkg::CSR_TIME, csr_pkg::CSR_CYCLEH, csr_pkg::CSR_TIMEH};
		m_tirq.m = (m_time >= m_mtimecmp);
		m_tirq.s = 1'b1; // stimecmp and utimecmp stay zero
		m_tirq.u = 1'b1;
		if (trap_req.pending)
		begin
			if (tgt == csr_pkg::MODE_M)
			begin
				m_mepc = trap_req.pc & ~32'h3;
				m_mcause = cause;
				m_status[7] = m_status[3];
				m_status[3] = 1'b0;
				m_status[12:11] = m_mode;
			end
			else if (tgt == csr_pkg::MODE_S)
			begin
				m_sepc = trap_req.pc & ~32'h3;
				m_scause = cause;
				m_status[5] = m_status[1];
				m_status[1] = 1'b0;
				m_status[8] = (m_mode != csr_pkg::MODE_U);
			end
			else
			begin
				m_uepc = trap_req.pc & ~32'h3;
				m_ucause = cause;
				m_status[4] = m_status[0];
				m_status[0] = 1'b0;
			end
			m_mode = tgt;
		end
		else if (ret == csr_pkg::RET_MRET)
		begin
			m_mode = csr_pkg::mode_t'(m_status[12:11]);
			m_status[3] = m_status[7];
			m_status[7] = 1'b1;
			m_status[12:11] = 2'b00;
		end
		else if (ret == csr_pkg::RET_SRET)
		begin
			m_mode = m_status[8] ? csr_pkg::MODE_S : csr_pkg::MODE_U;
			m_status[1] = m_status[5];
			m_status[5] = 1'b1;
			m_status[8] = 1'b0;
		end
		else if (ret == csr_pkg::RET_URET)
		begin
			m_mode = csr_pkg::MODE_U;
			m_status[0] = m_status[4];
			m_status[4] = 1'b1;
		end
		else if (csr_req.op != csr_pkg::CSR_NONE && !ro && !(csr_req.op != csr_pkg::CSR_RW
			&& csr_req.operand == '0))
		begin
			od = ref_read(csr_req.addr);
			case (csr_req.op)
				csr_pkg::CSR_RW: ref_write(csr_req.addr, csr_req.operand);
				csr_pkg::CSR_RS: ref_write(csr_req.addr, od | csr_req.operand);
				default: ref_write(csr_req.addr, od & ~csr_req.operand);
			endcase
		end
		m_time = m_time + 64'd1;
	endtask

	task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic check_mode(input string name, input csr_pkg::mode_t got,
		input csr_pkg::mode_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic check_irq_en(input string name, input csr_pkg::irq_en_t got,
		input csr_pkg::irq_en_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	// outputs settle after the falling-edge drive, registers move only in NBA
	always @(posedge clk)
	begin
		if (!nrst)
			model_reset();
		else
		begin
			check_data("rd_data", rd_data,
				(csr_req.op == csr_pkg::CSR_NONE) ? 32'h0 : ref_read(csr_req.addr));
			check_mode("current_mode", current_mode, m_mode);
			check_data("epc", epc, ref_epc());
			check_irq_en("irq_en", irq_en, ref_irq_en());
			check_data("timer_irq", 32'(timer_irq), 32'(m_tirq));
			model_step();
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= 4000)
		begin
			$display("run did not finish within 4000 cycles");
			$display("sim failed");
			$fatal(1);
		end
	end

	task automatic idle();
		@(negedge clk);
		csr_req = '0;
		trap_req = '0;
		ret = csr_pkg::RET_NONE;
	endtask

	task automatic csr_cycle(input csr_pkg::csr_op_t op, input csr_pkg::csr_addr_t a,
		input logic [31:0] d);
		idle();
		csr_req.op = op;
		csr_req.addr = a;
		csr_req.operand = d;
	endtask

	task automatic trap_cycle(input csr_pkg::cause_t code, input logic [31:0] pc);
		idle();
		trap_req.pending = 1'b1;
		trap_req.code = code;
		trap_req.pc = pc;
	endtask

	task automatic ret_cycle(input csr_pkg::ret_t r);
		idle();
		ret = r;
	endtask

	csr_pkg::csr_addr_t rand_addrs [8] = '{csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_MTVEC,
		csr_pkg::CSR_MIE, csr_pkg::CSR_MEDELEG, csr_pkg::CSR_MIDELEG, csr_pkg::CSR_SEDELEG,
		csr_pkg::CSR_SIDELEG, csr_pkg::CSR_SSCRATCH};
	logic [4:0] codes [14] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 11, 12, 13, 15};

	initial
	begin
		logic [31:0] r, a, d;
		int n;
		clk = 1'b0;
		nrst = 1'b0;
		cycles = 0;
		lfsr = 16'd13;
		csr_req = '0;
		trap_req = '0;
		ret = csr_pkg::RET_NONE;
		ext_irq = '0;
		repeat (16) @(negedge clk);
		nrst = 1'b1;

		for (int i = 0; i < 200; i++)
		begin
			rand_bits(2, r);
			rand_bits(3, a);
			rand_bits(32, d);
			if (d[2:0] == 3'd0)
				d = '0; // exercises the no-write case of set and clear
			csr_cycle(csr_pkg::csr_op_t'(r[1:0]), rand_addrs[a[2:0]], d);
		end

		csr_cycle(csr_pkg::CSR_RW, csr_pkg::CSR_MISA, 32'hffff_ffff);
		csr_cycle(csr_pkg::CSR_RS, csr_pkg::CSR_MISA, 32'h0);
		csr_cycle(csr_pkg::CSR_RW, csr_pkg::CSR_MVENDORID, 32'h1234_5678);
		csr_cycle(csr_pkg::CSR_RS, csr_pkg::CSR_MVENDORID, 32'h0);
		csr_cycle(csr_pkg::CSR_RS, csr_pkg::CSR_MHARTID, 32'h0);

		// M-mode trap and return
		rand_bits(4, r);
		rand_bits(32, d);
		trap_cycle(csr_pkg::cause_t'(codes[r % 14]), d);
		csr_cycle(csr_pkg::CSR_RS, csr_pkg::CSR_MEPC, 32'h0);
		csr_cycle(csr_pkg::CSR_RS, csr_pkg::CSR_MCAUSE, 32'h0);
		csr_cycle(csr_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 32'h0);
		ret_cycle(csr_pkg::RET_MRET);

		// delegation from U to U and S, then from S to S and M
		csr_cycle(csr_pkg::CSR_RW, csr_pkg::CSR_MEDELEG, 32'h0004);
		csr_cycle(csr_pkg::CSR_RW, csr_pkg::CSR_SEDELEG, 32'h0100);
		csr_cycle(csr_pkg::CSR_RW, csr_pkg::CSR_MSTATUS, 32'h0);
		ret_cycle(csr_pkg::RET_MRET);
		trap_cycle(csr_pkg::ECALL_U, 32'h0000_2000);
		csr_cycle(csr_pkg::CSR_RS, csr_pkg::CSR_UCAUSE, 32'h0);
		trap_cycle(csr_pkg::I_ILLEGAL, 32'h0000_2004);
		csr_cycle(csr_pkg::CSR_RS, csr_pkg::CSR_SCAUSE, 32'h0);
		trap_cycle(csr_pkg::I_ILLEGAL, 32'h0000_3000);
		trap_cycle(csr_pkg::BREAKPOINT, 32'h0000_3004);
		csr_cycle(csr_pkg::CSR_RS, csr_pkg::CSR_MCAUSE, 32'h0);

		for (int i = 0; i < 20; i++)
		begin
			rand_bits(32, d);
			csr_cycle(csr_pkg::CSR_RW, csr_pkg::CSR_MSTATUS, d);
			rand_bits(32, d);
			csr_cycle(csr_pkg::CSR_RW, csr_pkg::CSR_MIE, d);
			rand_bits(32, d);
			csr_cycle(csr_pkg::CSR_RW, csr_pkg::CSR_UIE, d);
		end

		// timer compare ahead of mtime
		csr_cycle(csr_pkg::CSR_RW, csr_pkg::CSR_MTIMECMP, m_time[31:0] + 32'd100);
		idle();
		idle();
		check_data("timer_irq.m", 32'(timer_irq.m), 32'h0);
		n = 0;
		while (!timer_irq.m)
		begin
			idle();
			n++;
			if (n > 200)
			begin
				$display("timer interrupt did not rise within 200 cycles");
				$display("sim failed");
				$fatal(1);
			end
		end
		csr_cycle(csr_pkg::CSR_RS, csr_pkg::CSR_MIP, 32'h0);
		@(posedge clk); // mip read still on the bus, before the edge updates
		check_data("mip[7]", 32'(rd_data[7]), 32'h1);
		idle();
		$display("sim passed");
		$finish;
	end

endmodule

/* csr_unit_top.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_unit_top (
	input logic clk,
	input logic nrst,
	input csr_pkg::csr_req_t csr_req,
	input csr_pkg::trap_req_t trap_req,
	input csr_pkg::ret_t ret,
	input csr_pkg::ext_irq_t ext_irq,
	output logic [`XLEN-1:0] rd_data,
	output csr_pkg::mode_t current_mode,
	output logic [`XLEN-1:0] epc,
	output csr_pkg::irq_en_t irq_en,
	output csr_pkg::timer_irq_t timer_irq
);

	logic [`XLEN-1:0] old_data;
	csr_pkg::wb_t wb;
	csr_pkg::mode_t next_mode;
	csr_pkg::mode_t mpp;
	logic spp;
	logic take_m, take_s, take_u;
	logic [`EDELEG_W-1:0] medeleg, sedeleg;
	logic [`IDELEG_W-1:0] mideleg, sideleg;
	logic [`TIME_W-1:0] mtime;
	logic [`TIME_W-1:0] mtimecmp, stimecmp, utimecmp;

	// every pending trap is taken into some mode, so pending alone blocks the write
	csr_alu u_alu (.req(csr_req), .old_data(old_data), .trap_taken(trap_req.pending),
		.wb(wb), .rd_data(rd_data));

	csr_timer u_timer (.clk(clk), .nrst(nrst), .mtimecmp(mtimecmp), .stimecmp(stimecmp),
		.utimecmp(utimecmp), .mtime(mtime), .timer_irq(timer_irq));

	csr_trap_ctrl u_trap_ctrl (.clk(clk), .nrst(nrst), .trap_req(trap_req), .ret(ret),
		.medeleg(medeleg), .sedeleg(sedeleg), .mideleg(mideleg), .sideleg(sideleg),
		.mpp(mpp), .spp(spp), .current_mode(current_mode), .next_mode(next_mode),
		.take_m(take_m), .take_s(take_s), .take_u(take_u));

	csr_regfile u_regfile (.clk(clk), .nrst(nrst), .rd_addr(csr_req.addr), .wb(wb),
		.trap_req(trap_req), .ret(ret), .current_mode(current_mode), .next_mode(next_mode),
		.take_m(take_m), .take_s(take_s), .take_u(take_u), .ext_irq(ext_irq),
		.timer_irq(timer_irq), .mtime(mtime), .old_data(old_data),
		.medeleg(medeleg), .sedeleg(sedeleg), .mideleg(mideleg), .sideleg(sideleg),
		.mpp(mpp), .spp(spp), .mtimecmp(mtimecmp), .stimecmp(stimecmp),
		.utimecmp(utimecmp), .epc(epc), .irq_en(irq_en));

endmodule

/* csr_regfile.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_regfile (
	input logic clk,
	input logic nrst,
	input csr_pkg::csr_addr_t rd_addr,
	input csr_pkg::wb_t wb,
	input csr_pkg::trap_req_t trap_req,
	input csr_pkg::ret_t ret,
	input csr_pkg::mode_t current_mode,
	input csr_pkg::mode_t next_mode,
	input logic take_m,
	input logic take_s,
	input logic take_u,
	input csr_pkg::ext_irq_t ext_irq,
	input csr_pkg::timer_irq_t timer_irq,
	input logic [`TIME_W-1:0] mtime,
	output logic [`XLEN-1:0] old_data,
	output logic [`EDELEG_W-1:0] medeleg,
	output logic [`EDELEG_W-1:0] sedeleg,
	output logic [`IDELEG_W-1:0] mideleg,
	output logic [`IDELEG_W-1:0] sideleg,
	output csr_pkg::mode_t mpp,
	output logic spp,
	output logic [`TIME_W-1:0] mtimecmp,
	output logic [`TIME_W-1:0] stimecmp,
	output logic [`TIME_W-1:0] utimecmp,
	output logic [`XLEN-1:0] epc,
	output csr_pkg::irq_en_t irq_en
);

	logic status_mie, status_sie, status_uie; // global enables
	logic status_mpie, status_spie, status_upie;
	logic meie, seie, ueie, mtie, stie, utie, usie, usip;
	logic [`XLEN-1:2] mtvec, stvec, utvec; // direct mode only
	logic [`XLEN-1:2] mepc, sepc, uepc;
	logic [`XLEN-1:0] mscratch, sscratch, uscratch;
	logic mcause_int, scause_int, ucause_int;
	logic [4:0] mcause_code, scause_code, ucause_code;
	logic [`XLEN-1:0] mtval, stval, utval;
	logic [`XLEN-1:0] mstatus, sstatus, ustatus;
	logic [`XLEN-1:0] mip, sip, uip;
	logic [`XLEN-1:0] mie, sie, uie;
	logic [`XLEN-1:0] mcause, scause, ucause;
	logic [`XLEN-1:0] trap_tval;
	logic [`XLEN-1:0] tvec;

	// sstatus and ustatus are restricted views of the same bits
	assign mstatus = {19'b0, mpp, 2'b0, spp, status_mpie, 1'b0, status_spie, status_upie,
		status_mie, 1'b0, status_sie, status_uie};
	assign sstatus = {23'b0, spp, 2'b0, status_spie, status_upie, 2'b0, status_sie, status_uie};
	assign ustatus = {27'b0, status_upie, 3'b0, status_uie};

	assign mip = {20'b0, ext_irq.m, 1'b0, ext_irq.s, ext_irq.u, timer_irq.m, 1'b0, timer_irq.s,
		timer_irq.u, 3'b0, usip};
	assign sip = {22'b0, ext_irq.s, ext_irq.u, 2'b0, timer_irq.s, timer_irq.u, 3'b0, usip};
	assign uip = {23'b0, ext_irq.u, 3'b0, timer_irq.u, 3'b0, usip};

	assign mie = {20'b0, meie, 1'b0, seie, ueie, mtie, 1'b0, stie, utie, 3'b0, usie};
	assign sie = {22'b0, seie, ueie, 2'b0, stie, utie, 3'b0, usie};
	assign uie = {23'b0, ueie, 3'b0, utie, 3'b0, usie};

	assign mcause = {mcause_int, {(`XLEN-6){1'b0}}, mcause_code};
	assign scause = {scause_int, {(`XLEN-6){1'b0}}, scause_code};
	assign ucause = {ucause_int, {(`XLEN-6){1'b0}}, ucause_code};

	// only a misaligned fetch reports its address
	assign trap_tval = (!trap_req.interrupt && trap_req.code == csr_pkg::I_ADDR_MISALIGNED)
		? trap_req.pc : '0;

	always_comb
	begin
		case (rd_addr)
			csr_pkg::CSR_MSTATUS: old_data = mstatus;
			csr_pkg::CSR_MISA: old_data = `MISA_VALUE;
			csr_pkg::CSR_MEDELEG: old_data = `XLEN'(medeleg);
			csr_pkg::CSR_MIDELEG: old_data = `XLEN'(mideleg);
			csr_pkg::CSR_MIE: old_data = mie;
			csr_pkg::CSR_MTVEC: old_data = {mtvec, 2'b00};
			csr_pkg::CSR_MSCRATCH: old_data = mscratch;
			csr_pkg::CSR_MEPC: old_data = {mepc, 2'b00};
			csr_pkg::CSR_MCAUSE: old_data = mcause;
			csr_pkg::CSR_MTVAL: old_data = mtval;
			csr_pkg::CSR_MIP: old_data = mip;
			csr_pkg::CSR_SSTATUS: old_data = sstatus;
			csr_pkg::CSR_SEDELEG: old_data = `XLEN'(sedeleg);
			csr_pkg::CSR_SIDELEG: old_data = `XLEN'(sideleg);
			csr_pkg::CSR_SIE: old_data = sie;
			csr_pkg::CSR_STVEC: old_data = {stvec, 2'b00};
			csr_pkg::CSR_SSCRATCH: old_data = sscratch;
			csr_pkg::CSR_SEPC: old_data = {sepc, 2'b00};
			csr_pkg::CSR_SCAUSE: old_data = scause;
			csr_pkg::CSR_STVAL: old_data = stval;
			csr_pkg::CSR_SIP: old_data = sip;
			csr_pkg::CSR_USTATUS: old_data = ustatus;
			csr_pkg::CSR_UIE: old_data = uie;
			csr_pkg::CSR_UTVEC: old_data = {utvec, 2'b00};
			csr_pkg::CSR_USCRATCH: old_data = uscratch;
			csr_pkg::CSR_UEPC: old_data = {uepc, 2'b00};
			csr_pkg::CSR_UCAUSE: old_data = ucause;
			csr_pkg::CSR_UTVAL: old_data = utval;
			csr_pkg::CSR_UIP: old_data = uip;
			csr_pkg::CSR_MTIMECMP: old_data = mtimecmp[`XLEN-1:0];
			csr_pkg::CSR_STIMECMP: old_data = stimecmp[`XLEN-1:0];
			csr_pkg::CSR_UTIMECMP: old_data = utimecmp[`XLEN-1:0];
			csr_pkg::CSR_CYCLE, csr_pkg::CSR_TIME: old_data = mtime[`XLEN-1:0];
			csr_pkg::CSR_CYCLEH, csr_pkg::CSR_TIMEH: old_data = mtime[`TIME_W-1:`XLEN];
			default: old_data = '0; // id registers and unimplemented addresses
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			{status_mie, status_sie, status_uie} <= '0;
			{status_mpie, status_spie, status_upie} <= '0;
			mpp <= csr_pkg::MODE_M;
			spp <= 1'b0;
			{meie, seie, ueie, mtie, stie, utie, usie, usip} <= '0;
			{mtvec, stvec, utvec} <= '0;
			{mepc, sepc, uepc} <= '0;
			{mscratch, sscratch, uscratch} <= '0;
			{mcause_int, mcause_code, scause_int, scause_code} <= '0;
			{ucause_int, ucause_code} <= '0;
			{mtval, stval, utval} <= '0;
			{medeleg, mideleg, sedeleg, sideleg} <= '0;
			{mtimecmp, stimecmp, utimecmp} <= '0;
		end
		else if (take_m)
		begin
			mepc <= trap_req.pc[`XLEN-1:2];
			{mcause_int, mcause_code} <= {trap_req.interrupt, trap_req.code};
			mtval <= trap_tval;
			status_mpie <= status_mie;
			status_mie <= 1'b0;
			mpp <= current_mode;
		end
		else if (take_s)
		begin
			sepc <= trap_req.pc[`XLEN-1:2];
			{scause_int, scause_code} <= {trap_req.interrupt, trap_req.code};
			stval <= trap_tval;
			status_spie <= status_sie;
			status_sie <= 1'b0;
			spp <= (current_mode != csr_pkg::MODE_U);
		end
		else if (take_u)
		begin
			uepc <= trap_req.pc[`XLEN-1:2];
			{ucause_int, ucause_code} <= {trap_req.interrupt, trap_req.code};
			utval <= trap_tval;
			status_upie <= status_uie;
			status_uie <= 1'b0;
		end
		else if (ret == csr_pkg::RET_MRET)
		begin
			status_mie <= status_mpie;
			status_mpie <= 1'b1;
			mpp <= csr_pkg::MODE_U;
		end
		else if (ret == csr_pkg::RET_SRET)
		begin
			status_sie <= status_spie;
			status_spie <= 1'b1;
			spp <= 1'b0;
		end
		else if (ret == csr_pkg::RET_URET)
		begin
			status_uie <= status_upie;
			status_upie <= 1'b1;
		end
		else if (wb.we)
		begin
			case (wb.addr)
				csr_pkg::CSR_MSTATUS:
				begin
					{status_mpie, status_spie, status_upie} <= {wb.data[7], wb.data[5:4]};
					{status_mie, status_sie, status_uie} <= {wb.data[3], wb.data[1:0]};
					spp <= wb.data[8];
					if (wb.data[12:11] != 2'b10) // reserved encoding, mpp unchanged
						mpp <= csr_pkg::mode_t'(wb.data[12:11]);
				end
				csr_pkg::CSR_SSTATUS:
				begin
					{status_spie, status_upie} <= wb.data[5:4];
					{status_sie, status_uie} <= wb.data[1:0];
					spp <= wb.data[8];
				end
				csr_pkg::CSR_USTATUS: {status_upie, status_uie} <= {wb.data[4], wb.data[0]};
				csr_pkg::CSR_MIE: {meie, seie, ueie, mtie, stie, utie, usie} <=
					{wb.data[11], wb.data[9:7], wb.data[5:4], wb.data[0]};
				csr_pkg::CSR_SIE: {seie, ueie, stie, utie, usie} <=
					{wb.data[9:8], wb.data[5:4], wb.data[0]};
				csr_pkg::CSR_UIE: {ueie, utie, usie} <= {wb.data[8], wb.data[4], wb.data[0]};
				csr_pkg::CSR_MIP, csr_pkg::CSR_SIP, csr_pkg::CSR_UIP: usip <= wb.data[0];
				csr_pkg::CSR_MTVEC: mtvec <= wb.data[`XLEN-1:2];
				csr_pkg::CSR_STVEC: stvec <= wb.data[`XLEN-1:2];
				csr_pkg::CSR_UTVEC: utvec <= wb.data[`XLEN-1:2];
				csr_pkg::CSR_MEPC: mepc <= wb.data[`XLEN-1:2];
				csr_pkg::CSR_SEPC: sepc <= wb.data[`XLEN-1:2];
				csr_pkg::CSR_UEPC: uepc <= wb.data[`XLEN-1:2];
				csr_pkg::CSR_MSCRATCH: mscratch <= wb.data;
				csr_pkg::CSR_SSCRATCH: sscratch <= wb.data;
				csr_pkg::CSR_USCRATCH: uscratch <= wb.data;
				csr_pkg::CSR_MCAUSE: {mcause_int, mcause_code} <= {wb.data[31], wb.data[4:0]};
				csr_pkg::CSR_SCAUSE: {scause_int, scause_code} <= {wb.data[31], wb.data[4:0]};
				csr_pkg::CSR_UCAUSE: {ucause_int, ucause_code} <= {wb.data[31], wb.data[4:0]};
				csr_pkg::CSR_MTVAL: mtval <= wb.data;
				csr_pkg::CSR_STVAL: stval <= wb.data;
				csr_pkg::CSR_UTVAL: utval <= wb.data;
				csr_pkg::CSR_MEDELEG: medeleg <= wb.data[`EDELEG_W-1:0];
				csr_pkg::CSR_MIDELEG: mideleg <= wb.data[`IDELEG_W-1:0];
				csr_pkg::CSR_SEDELEG: sedeleg <= wb.data[`EDELEG_W-1:0];
				csr_pkg::CSR_SIDELEG: sideleg <= wb.data[`IDELEG_W-1:0];
				csr_pkg::CSR_MTIMECMP: mtimecmp <= `TIME_W'(wb.data); // upper half cleared
				csr_pkg::CSR_STIMECMP: stimecmp <= `TIME_W'(wb.data);
				csr_pkg::CSR_UTIMECMP: utimecmp <= `TIME_W'(wb.data);
				default: ;
			endcase
		end
	end

	// per-source enable gated by the global enable of its mode
	assign irq_en.m_eie = meie & status_mie;
	assign irq_en.m_tie = mtie & status_mie;
	assign irq_en.s_eie = seie & status_sie;
	assign irq_en.s_tie = stie & status_sie;
	assign irq_en.u_eie = ueie & status_uie;
	assign irq_en.u_tie = utie & status_uie;
	assign irq_en.u_sie = usie & status_uie;

	// redirect target for the front end, valid in the request cycle
	always_comb
	begin
		case (next_mode)
			csr_pkg::MODE_M: tvec = {mtvec, 2'b00};
			csr_pkg::MODE_S: tvec = {stvec, 2'b00};
			default: tvec = {utvec, 2'b00};
		endcase
		if (trap_req.pending)
			epc = tvec;
		else if (ret == csr_pkg::RET_MRET)
			epc = {mepc, 2'b00};
		else if (ret == csr_pkg::RET_SRET)
			epc = {sepc, 2'b00};
		else if (ret == csr_pkg::RET_URET)
			epc = {uepc, 2'b00};
		else
			epc = tvec;
	end

endmodule

/* csr_trap_ctrl.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_trap_ctrl (
	input logic clk,
	input logic nrst,
	input csr_pkg::trap_req_t trap_req,
	input csr_pkg::ret_t ret,
	input logic [`EDELEG_W-1:0] medeleg,
	input logic [`EDELEG_W-1:0] sedeleg,
	input logic [`IDELEG_W-1:0] mideleg,
	input logic [`IDELEG_W-1:0] sideleg,
	input csr_pkg::mode_t mpp,
	input logic spp,
	output csr_pkg::mode_t current_mode,
	output csr_pkg::mode_t next_mode,
	output logic take_m,
	output logic take_s,
	output logic take_u
);

	logic [31:0] m_mask; // medeleg or mideleg, widened to the 5-bit code range
	logic [31:0] s_mask;
	logic to_s;
	logic to_u;
	csr_pkg::mode_t trap_mode;
	csr_pkg::mode_t ret_mode;

	assign m_mask = trap_req.interrupt ? 32'(mideleg) : 32'(medeleg);
	assign s_mask = trap_req.interrupt ? 32'(sideleg) : 32'(sedeleg);
	assign to_s = m_mask[trap_req.code];
	assign to_u = s_mask[trap_req.code];

	// M keeps everything, S and U hand a trap one level down if delegated
	always_comb
	begin
		trap_mode = csr_pkg::MODE_M;
		if (current_mode == csr_pkg::MODE_S && to_s)
			trap_mode = csr_pkg::MODE_S;
		else if (current_mode == csr_pkg::MODE_U)
		begin
			if (to_u)
				trap_mode = csr_pkg::MODE_U;
			else
				trap_mode = csr_pkg::MODE_S;
		end
	end

	always_comb
	begin
		ret_mode = current_mode;
		case (ret)
			csr_pkg::RET_MRET: ret_mode = mpp;
			csr_pkg::RET_SRET:
			begin
				if (spp)
					ret_mode = csr_pkg::MODE_S;
				else
					ret_mode = csr_pkg::MODE_U;
			end
			csr_pkg::RET_URET: ret_mode = csr_pkg::MODE_U;
			default: ret_mode = current_mode;
		endcase
	end

	// trap has priority over a return in the same cycle
	always_comb
	begin
		if (trap_req.pending)
			next_mode = trap_mode;
		else
			next_mode = ret_mode;
	end

	assign take_m = trap_req.pending && (trap_mode == csr_pkg::MODE_M);
	assign take_s = trap_req.pending && (trap_mode == csr_pkg::MODE_S);
	assign take_u = trap_req.pending && (trap_mode == csr_pkg::MODE_U);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			current_mode <= csr_pkg::MODE_M;
		else
			current_mode <= next_mode;
	end

endmodule

/* csr_timer.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_timer (
	input logic clk,
	input logic nrst,
	input logic [`TIME_W-1:0] mtimecmp,
	input logic [`TIME_W-1:0] stimecmp,
	input logic [`TIME_W-1:0] utimecmp,
	output logic [`TIME_W-1:0] mtime,
	output csr_pkg::timer_irq_t timer_irq
);

	// free-running, doubles as the cycle counter
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mtime <= '0;
		end
		else
		begin
			mtime <= mtime + `TIME_W'(1);
		end
	end

	// compare results registered, so pending lags mtime by a cycle
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			timer_irq <= '0;
		end
		else
		begin
			timer_irq.m <= (mtime >= mtimecmp);
			timer_irq.s <= (mtime >= stimecmp);
			timer_irq.u <= (mtime >= utimecmp);
		end
	end

endmodule

/* csr_alu.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_alu (
	input csr_pkg::csr_req_t req,
	input logic [`XLEN-1:0] old_data,
	input logic trap_taken,
	output csr_pkg::wb_t wb,
	output logic [`XLEN-1:0] rd_data
);

	logic [`XLEN-1:0] new_data;
	logic read_only;
	logic no_change;

	always_comb
	begin
		case (req.op)
			csr_pkg::CSR_RW: new_data = req.operand;
			csr_pkg::CSR_RS: new_data = old_data | req.operand;
			csr_pkg::CSR_RC: new_data = old_data & ~req.operand;
			default: new_data = old_data;
		endcase
	end

	// counters and id registers live at 0xc00 and up, plus misa
	assign read_only = (req.addr[11:10] == 2'b11) || (req.addr == csr_pkg::CSR_MISA);

	// csrrs/csrrc with an all-zero mask must not write
	assign no_change = (req.op inside {csr_pkg::CSR_RS, csr_pkg::CSR_RC})
		&& (req.operand == '0);

	assign wb.we = (req.op != csr_pkg::CSR_NONE) && !no_change && !read_only
		&& !trap_taken; // the trapping instruction does not retire
	assign wb.addr = req.addr;
	assign wb.data = new_data;

	assign rd_data = (req.op == csr_pkg::CSR_NONE) ? '0 : old_data; // old value to rd

endmodule

/* csr_pkg.sv */
`include "csr_defines.svh"

package csr_pkg;

	typedef enum logic [1:0] {
		MODE_U = 2'd0,
		MODE_S = 2'd1,
		MODE_M = 2'd3
	} mode_t;

	// timecmp addresses sit in the custom read/write ranges
	typedef enum logic [11:0] {
		CSR_USTATUS = 12'h000, CSR_UIE = 12'h004, CSR_UTVEC = 12'h005,
		CSR_USCRATCH = 12'h040, CSR_UEPC = 12'h041, CSR_UCAUSE = 12'h042,
		CSR_UTVAL = 12'h043, CSR_UIP = 12'h044,
		CSR_SSTATUS = 12'h100, CSR_SEDELEG = 12'h102, CSR_SIDELEG = 12'h103,
		CSR_SIE = 12'h104, CSR_STVEC = 12'h105, CSR_SSCRATCH = 12'h140,
		CSR_SEPC = 12'h141, CSR_SCAUSE = 12'h142, CSR_STVAL = 12'h143,
		CSR_SIP = 12'h144,
		CSR_MSTATUS = 12'h300, CSR_MISA = 12'h301, CSR_MEDELEG = 12'h302,
		CSR_MIDELEG = 12'h303, CSR_MIE = 12'h304, CSR_MTVEC = 12'h305,
		CSR_MSCRATCH = 12'h340, CSR_MEPC = 12'h341, CSR_MCAUSE = 12'h342,
		CSR_MTVAL = 12'h343, CSR_MIP = 12'h344,
		CSR_STIMECMP = 12'h5c0, CSR_MTIMECMP = 12'h7c0, CSR_UTIMECMP = 12'h800,
		CSR_CYCLE = 12'hc00, CSR_TIME = 12'hc01, CSR_CYCLEH = 12'hc80,
		CSR_TIMEH = 12'hc81,
		CSR_MVENDORID = 12'hf11, CSR_MARCHID = 12'hf12, CSR_MIMPID = 12'hf13,
		CSR_MHARTID = 12'hf14
	} csr_addr_t;

	typedef enum logic [1:0] {CSR_NONE, CSR_RW, CSR_RS, CSR_RC} csr_op_t;

	typedef enum logic [1:0] {RET_NONE, RET_MRET, RET_SRET, RET_URET} ret_t;

	typedef enum logic [4:0] {
		I_ADDR_MISALIGNED = 5'd0, I_ACCESS_FAULT = 5'd1, I_ILLEGAL = 5'd2,
		BREAKPOINT = 5'd3, L_ADDR_MISALIGNED = 5'd4, L_ACCESS_FAULT = 5'd5,
		S_ADDR_MISALIGNED = 5'd6, S_ACCESS_FAULT = 5'd7, ECALL_U = 5'd8,
		ECALL_S = 5'd9, ECALL_M = 5'd11, I_PAGE_FAULT = 5'd12,
		L_PAGE_FAULT = 5'd13, S_PAGE_FAULT = 5'd15
	} cause_t;

	typedef struct packed {
		csr_op_t op;
		csr_addr_t addr;
		logic [`XLEN-1:0] operand;
	} csr_req_t;

	typedef struct packed {
		logic pending;
		logic interrupt;
		cause_t code; // interrupt number when interrupt is set
		logic [`XLEN-1:0] pc;
	} trap_req_t;

	typedef struct packed {
		logic m;
		logic s;
		logic u;
	} ext_irq_t;

	typedef struct packed {
		logic m;
		logic s;
		logic u;
	} timer_irq_t;

	typedef struct packed {
		logic m_eie;
		logic m_tie;
		logic s_eie;
		logic s_tie;
		logic u_eie;
		logic u_tie;
		logic u_sie;
	} irq_en_t;

	typedef struct packed {
		logic we;
		csr_addr_t addr;
		logic [`XLEN-1:0] data;
	} wb_t;

endpackage

/* csr_defines.svh */
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// data path width
`define XLEN 32

// mtime and the timer compare registers
`define TIME_W 64

// implemented medeleg/sedeleg bits
`define EDELEG_W 16

// implemented mideleg/sideleg bits
`define IDELEG_W 12

// MXL=1 with I, M, N, S and U
`define MISA_VALUE 32'h4014_3100

`endif
